// File: arrayAllocator.sv
// Hands out array numbers, reusing freed ones last in first out
// The caller must not allocate while exhausted nor release a free array
`timescale 1ns/1ps
`default_nettype none
`include "heap_defines.svh"

module arrayAllocator import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         allocate,                        // Take the granted number
  input  logic         releaseArray,                    // Return array to the pool
  input  arrayNumber_t array,                           // Array checked or freed
  output logic         isAllocated,                     // Flag of the addressed array
  output arraySize_t   highWater,                       // Arrays ever handed out
  output arrayNumber_t granted,                         // Number the next alloc gets
  output logic         exhausted                        // Nothing left to grant
);

  arrayNumber_t              freeStack [`HEAP_ARRAYS];  // Freed numbers, newest on top
  logic [`HEAP_ARRAY_BITS:0] stackTop;                  // Entries on the free stack
  logic [`HEAP_ARRAYS-1:0]   allocated;                 // One flag per array

  assign isAllocated = allocated[array];
  assign exhausted   = stackTop == '0 && highWater == `HEAP_ARRAYS;
  assign granted     = stackTop != '0 ? freeStack[arrayNumber_t'(stackTop - 1'b1)]
                                      : arrayNumber_t'(highWater);  // Reuse first

  always_ff @(posedge clock) begin
    if (reset) begin
      stackTop  <= '0;
      highWater <= '0;
      allocated <= '0;
    end else if (allocate) begin
      if (stackTop != '0) begin
        stackTop <= stackTop - 1'b1;                    // Pop a freed number
      end else begin
        highWater <= highWater + 1'b1;                  // Fresh number
      end
      allocated[granted] <= 1'b1;
    end else if (releaseArray) begin
      stackTop         <= stackTop + 1'b1;
      allocated[array] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray) begin
      freeStack[arrayNumber_t'(stackTop)] <= array;     // Push onto the stack
    end
  end

  // A double free must be stopped by the controller's check cycle
  assert property (@(posedge clock) disable iff (reset) releaseArray |-> allocated[array])
    else $error("release of an array that is not allocated");

endmodule

`default_nettype wire

// File: arrayHeap.sv
// Array heap behind a Wishbone classic handshake with loose request fields
// Request fields must stay steady from strobe until acknowledge
`timescale 1ns/1ps
`default_nettype none

module arrayHeap import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          cycle,
  input  logic          strobe,
  output logic          acknowledge,
  input  heapAction_t   action,
  input  arrayNumber_t  array,
  input  elementIndex_t index,
  input  element_t      dataIn,
  output element_t      dataOut,
  output heapError_t    error
);

  logic          isAllocated, exhausted, allocate, releaseArray;   // Allocator
  arraySize_t    highWater;
  arrayNumber_t  granted, storeArray;
  logic          writeEnable, sizeWrite;                           // Store
  elementIndex_t writeIndex, scanIndex;
  element_t      writeData, readData, scanData;
  arraySize_t    newSize, size;
  logic          load;                                             // ALU
  element_t      newValue, returnValue;
  logic          start, greater, done;                             // Range scan
  arraySize_t    count;

  heapControl u_control (
    .clock, .reset, .cycle, .strobe, .action, .array, .index, .dataIn,
    .isAllocated, .highWater, .granted, .exhausted, .size, .readData,
    .newValue, .returnValue, .done, .count, .acknowledge, .dataOut, .error,
    .allocate, .releaseArray, .storeArray, .writeEnable, .writeIndex,
    .writeData, .sizeWrite, .newSize, .load, .start, .greater
  );

  arrayAllocator u_allocator (
    .clock, .reset, .allocate, .releaseArray, .array(storeArray),
    .isAllocated, .highWater, .granted, .exhausted
  );

  elementStore u_store (
    .clock, .reset, .array(storeArray), .index(writeIndex), .writeEnable,
    .writeData, .sizeWrite, .newSize, .scanIndex, .readData, .size, .scanData
  );

  elementAlu u_alu (
    .clock, .load, .action, .operand(readData), .dataIn, .newValue, .returnValue
  );

  rangeCounter u_counter (
    .clock, .reset, .start, .greater, .size, .dataIn, .scanData,
    .scanIndex, .done, .count
  );

endmodule

`default_nettype wire

// File: heapModel.svh
// Behavioral model of the array heap, included inside the testbench module
// Needs heapPkg imported and the width macros defined before inclusion
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

arrayNumber_t modelFreeStack [`HEAP_ARRAYS];               // Freed numbers, newest last
int           modelStackTop;
logic         modelAllocated [`HEAP_ARRAYS];
int           modelHighWater;                              // Arrays ever granted
arraySize_t   modelSizes     [`HEAP_ARRAYS];
element_t     modelElements  [`HEAP_ARRAYS][`HEAP_LENGTH];
element_t     modelLastOut;                                // dataOut held between acks

function automatic void resetModel();
  modelStackTop  = 0;
  modelHighWater = 0;
  modelLastOut   = '0;
  for (int a = 0; a < `HEAP_ARRAYS; a++) begin
    modelAllocated[a] = 1'b0;
    modelSizes[a]     = '0;
  end
endfunction

// Applies one request and predicts error and dataOut
function automatic void predict(input heapAction_t act, input arrayNumber_t arr,
                                input elementIndex_t idx, input element_t data,
                                output heapError_t err, output element_t out);
  arraySize_t   sz;
  element_t     old;
  element_t     updated;
  arrayNumber_t number;
  int           hits;
  logic         inPlace;
  err     = errNone;
  out     = modelLastOut;                                  // Failures keep the old value
  sz      = modelSizes[arr];
  inPlace = act inside {actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd};
  if (act == actAlloc) begin
    if (modelStackTop == 0 && modelHighWater == `HEAP_ARRAYS) err = errOutOfMemory;
  end else if (int'(arr) >= modelHighWater) begin
    err = errUnallocated;
  end else if (!modelAllocated[arr]) begin
    err = errFreed;
  end else if ((act == actRead || inPlace) && idx >= sz) begin
    err = errOutOfBounds;
  end else if (act == actPush && sz == `HEAP_LENGTH) begin
    err = errFull;
  end else if (act == actPop && sz == 0) begin
    err = errEmpty;
  end
  if (err == errNone) begin
    case (act)
      actAlloc: begin
        if (modelStackTop > 0) begin
          modelStackTop--;                                 // Most recent free first
          number = modelFreeStack[modelStackTop];
        end else begin
          number = arrayNumber_t'(modelHighWater);
          modelHighWater++;
        end
        modelAllocated[number] = 1'b1;
        modelSizes[number]     = '0;
        out = element_t'(number);
      end
      actFree: begin
        modelAllocated[arr]           = 1'b0;
        modelFreeStack[modelStackTop] = arr;
        modelStackTop++;
      end
      actWrite: begin
        modelElements[arr][idx] = data;
        if (idx >= sz) modelSizes[arr] = arraySize_t'(idx) + 1'b1;  // Grow to cover
        out = data;
      end
      actRead: out = modelElements[arr][idx];
      actSize: out = element_t'(sz);
      actPush: begin
        modelElements[arr][elementIndex_t'(sz)] = data;
        modelSizes[arr] = sz + 1'b1;
        out = data;
      end
      actPop: begin
        modelSizes[arr] = sz - 1'b1;
        out = modelElements[arr][elementIndex_t'(sz - 1'b1)];
      end
      actLess, actGreater: begin
        hits = 0;
        for (int i = 0; i < int'(sz); i++) begin
          if (act == actLess ? modelElements[arr][i] < data : modelElements[arr][i] > data)
            hits++;
        end
        out = element_t'(hits);
      end
      default: begin
        old = modelElements[arr][idx];
        case (act)
          actAdd, actAddAfter:      updated = old + data;
          actSubtract, actSubAfter: updated = old - data;  // Wraps at 12 bits
          actOr:                    updated = old | data;
          actXor:                   updated = old ^ data;
          default:                  updated = old & data;
        endcase
        modelElements[arr][idx] = updated;
        out = (act == actAddAfter || act == actSubAfter) ? old : updated;
      end
    endcase
  end
  modelLastOut = out;
endfunction

`endif

// File: arrayHeapTb.sv
// Testbench of the array heap with directed phases and LFSR driven random requests
// Responses are checked against the included model and the first mismatch stops the run
`timescale 1ns/1ps
`default_nettype none
`include "heap_defines.svh"

module arrayHeapTb import heapPkg::*; ();

  localparam int RESET_CYCLES      = 10;
  localparam int DIRECTED_REQUESTS = 115;                  // Sum of the directed phases
  localparam int RANDOM_REQUESTS   = 400;
  localparam int REQUEST_COUNT     = DIRECTED_REQUESTS + RANDOM_REQUESTS;

  logic          clock = 1'b0;
  logic          reset;
  logic          cycle;
  logic          strobe;
  logic          acknowledge;
  heapAction_t   action;
  arrayNumber_t  array;
  elementIndex_t index;
  element_t      dataIn;
  element_t      dataOut;
  heapError_t    error;

  logic [31:0]   lfsrState = 32'd99869;                    // Fixed seed
  string         phase;
  int            requestNumber = 0;

  `include "heapModel.svh"

  arrayHeap u_dut (
    .clock, .reset, .cycle, .strobe, .acknowledge, .action, .array, .index,
    .dataIn, .dataOut, .error
  );

  always #2 clock = ~clock;                                // 4 ns period

  // ------------------------------
  // Random source
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32,22,2,1
  endfunction

  function automatic logic [15:0] randomBits(input int count);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);                     // One step per bit
      value     = {value[14:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic arrayNumber_t pickAllocated();
    arrayNumber_t candidate;
    candidate = arrayNumber_t'(randomBits(3));
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      if (modelAllocated[candidate]) return candidate;
      candidate = candidate + 1'b1;                        // Walk to next allocated
    end
    return candidate;                                      // None allocated
  endfunction

  // ------------------------------
  // Checks
  task automatic compareError(input string name, input heapError_t expected,
                              input heapError_t actual);
    if (actual !== expected) begin
      $display("mismatch %s error expected %s actual %s", name, expected.name(), actual.name());
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic compareElement(input string name, input element_t expected,
                                input element_t actual);
    if (actual !== expected) begin
      $display("mismatch %s dataOut expected %0h actual %0h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic compareArray(input string name, input arrayNumber_t expected,
                              input arrayNumber_t actual);
    if (actual !== expected) begin
      $display("mismatch %s granted expected %0d actual %0d", name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // One full handshake and its comparison with the model
  task automatic request(input heapAction_t act, input arrayNumber_t arr,
                         input elementIndex_t idx, input element_t data);
    heapError_t expError;
    element_t   expOut;
    string      name;
    @(posedge clock);
    cycle  <= 1'b1;
    strobe <= 1'b1;
    action <= act;
    array  <= arr;
    index  <= idx;
    dataIn <= data;
    @(negedge clock);
    while (!acknowledge) @(negedge clock);                 // Sample mid cycle
    predict(act, arr, idx, data, expError, expOut);
    name = $sformatf("%s #%0d %s", phase, requestNumber, act.name());
    compareError(name, expError, error);
    if (act == actAlloc && expError == errNone) begin
      compareArray(name, arrayNumber_t'(expOut), arrayNumber_t'(dataOut));
    end
    compareElement(name, expOut, dataOut);                 // Full width, upper bits too
    requestNumber++;
    @(posedge clock);
    cycle  <= 1'b0;                                        // Drop after acknowledge
    strobe <= 1'b0;
    @(negedge clock);
    if (acknowledge) begin
      $display("acknowledge of %s stayed high for more than one cycle", name);
      $display("Test FAILED");
      $fatal(1);
    end
    compareElement(name, expOut, dataOut);                 // Held after acknowledge
  endtask

  // ------------------------------
  // Watchdog
  initial begin
    repeat (RESET_CYCLES + REQUEST_COUNT * (`HEAP_LENGTH + 4)) @(posedge clock);
    $display("timeout, acknowledge did not arrive within the cycle budget");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    heapAction_t  act;
    arrayNumber_t arr;
    reset  = 1'b1;
    cycle  = 1'b0;
    strobe = 1'b0;
    action = actAlloc;
    array  = '0;
    index  = '0;
    dataIn = '0;
    resetModel();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    phase = "unallocated";                                 // Nothing granted yet
    request(actRead, 3'd3, 3'd0, '0);
    request(actSize, 3'd5, 3'd0, '0);
    request(actFree, 3'd0, 3'd0, '0);
    request(actPush, 3'd1, 3'd0, 12'h5a5);

    phase = "alloc";
    for (int a = 0; a <= `HEAP_ARRAYS; a++) request(actAlloc, '0, '0, '0);  // Last one fails

    phase = "push";                                        // Fills every element
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int i = 0; i < `HEAP_LENGTH; i++)
        request(actPush, arrayNumber_t'(a), '0, element_t'(randomBits(12)));
    end
    request(actPush, 3'd0, 3'd0, 12'h123);                 // Full

    phase = "count";
    request(actLess, 3'd0, 3'd0, element_t'(randomBits(12)));
    request(actGreater, 3'd0, 3'd0, element_t'(randomBits(12)));

    phase = "pop";
    for (int i = 0; i <= `HEAP_LENGTH; i++) request(actPop, 3'd7, 3'd0, '0);  // Ends empty

    phase = "write";
    request(actWrite, 3'd7, 3'd5, element_t'(randomBits(12)));
    request(actSize, 3'd7, 3'd0, '0);
    request(actRead, 3'd7, 3'd5, '0);
    request(actRead, 3'd7, 3'd6, '0);                      // Past the size

    phase = "free";
    request(actFree, 3'd2, 3'd0, '0);
    request(actFree, 3'd5, 3'd0, '0);
    request(actFree, 3'd5, 3'd0, '0);                      // Double free
    request(actRead, 3'd2, 3'd0, '0);
    request(actSize, 3'd2, 3'd0, '0);
    repeat (3) request(actAlloc, '0, '0, '0);              // Reuse 5, 2, then none

    phase = "inplace";
    for (int op = actAdd; op <= actAnd; op++) begin
      request(heapAction_t'(op), 3'd0, 3'd3, element_t'(randomBits(12)));
      request(actRead, 3'd0, 3'd3, '0);                    // Confirm stored value
    end

    phase = "random";
    for (int n = 0; n < RANDOM_REQUESTS; n++) begin
      act = heapAction_t'(randomBits(4));
      if (randomBits(2) != 0) arr = pickAllocated();        // Mostly live arrays
      else arr = arrayNumber_t'(randomBits(3));
      request(act, arr, elementIndex_t'(randomBits(3)), element_t'(randomBits(12)));
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
heapPkg.sv
arrayAllocator.sv
elementStore.sv
elementAlu.sv
rangeCounter.sv
heapControl.sv
arrayHeap.sv
arrayHeapTb.sv

// File: elementAlu.sv
// In-place arithmetic and logic on one element
// Results are registered one cycle after load
`timescale 1ns/1ps
`default_nettype none

module elementAlu import heapPkg::*; (
  input  logic        clock,
  input  logic        load,                             // Capture the result
  input  heapAction_t action,
  input  element_t    operand,                          // Current element value
  input  element_t    dataIn,
  output element_t    newValue,                         // Value written back
  output element_t    returnValue                       // Value for the client
);

  element_t result;

  always_comb begin
    case (action)
      actAdd, actAddAfter:      result = operand + dataIn;
      actSubtract, actSubAfter: result = operand - dataIn;  // Wraps modulo width
      actOr:                    result = operand | dataIn;
      actXor:                   result = operand ^ dataIn;
      actAnd:                   result = operand & dataIn;
      default:                  result = operand;
    endcase
  end

  always_ff @(posedge clock) begin
    if (load) begin
      newValue    <= result;
      returnValue <= (action == actAddAfter || action == actSubAfter) ? operand
                                                                      : result;
    end
  end

endmodule

`default_nettype wire

// File: elementStore.sv
// Element memory and per-array sizes of the heap
// Reads are combinational, writes land at the clock edge
`timescale 1ns/1ps
`default_nettype none
`include "heap_defines.svh"

module elementStore import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  arrayNumber_t  array,                          // Array under request
  input  elementIndex_t index,                          // Read and write position
  input  logic          writeEnable,
  input  element_t      writeData,
  input  logic          sizeWrite,                      // Replace the array's size
  input  arraySize_t    newSize,
  input  elementIndex_t scanIndex,                      // Second read position
  output element_t      readData,
  output arraySize_t    size,                           // Size of the addressed array
  output element_t      scanData
);

  element_t   elements [`HEAP_ARRAYS][`HEAP_LENGTH];    // Fixed block per array
  arraySize_t sizes    [`HEAP_ARRAYS];

  assign readData = elements[array][index];
  assign size     = sizes[array];
  assign scanData = elements[array][scanIndex];         // Used by the range scan

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      elements[array][index] <= writeData;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;                                 // All arrays empty
      end
    end else if (sizeWrite) begin
      sizes[array] <= newSize;
    end
  end

  // Sizes computed by the controller stay within one array
  assert property (@(posedge clock) disable iff (reset)
                   sizeWrite |-> newSize <= `HEAP_LENGTH)
    else $error("size beyond array length");

endmodule

`default_nettype wire

// File: heapControl.sv
// Request FSM of the heap: latch, check, optional scan wait, execute
// Acknowledge is combinational in the execute state, one request at a time
`timescale 1ns/1ps
`default_nettype none
`include "heap_defines.svh"

module heapControl import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          cycle,
  input  logic          strobe,
  input  heapAction_t   action,
  input  arrayNumber_t  array,
  input  elementIndex_t index,
  input  element_t      dataIn,
  input  logic          isAllocated,
  input  arraySize_t    highWater,
  input  arrayNumber_t  granted,
  input  logic          exhausted,
  input  arraySize_t    size,
  input  element_t      readData,
  input  element_t      newValue,
  input  element_t      returnValue,
  input  logic          done,
  input  arraySize_t    count,
  output logic          acknowledge,
  output element_t      dataOut,
  output heapError_t    error,
  output logic          allocate,
  output logic          releaseArray,
  output arrayNumber_t  storeArray,
  output logic          writeEnable,
  output elementIndex_t writeIndex,                     // Store position, read or write
  output element_t      writeData,
  output logic          sizeWrite,
  output arraySize_t    newSize,
  output logic          load,
  output logic          start,
  output logic          greater
);

  typedef enum logic [1:0] {sIdle, sCheck, sWait, sExecute} state_t;

  state_t        state;
  heapAction_t   reqAction;                             // Latched request
  arrayNumber_t  reqArray;
  elementIndex_t reqIndex;
  element_t      reqData;
  heapError_t    checkError;                            // Verdict of the check cycle
  heapError_t    errorQ;
  element_t      heldOut;                               // Last returned value
  element_t      result;
  logic          inPlace;
  logic          counting;
  logic          commit;                                // Execute a legal request

  assign inPlace     = reqAction inside {actAdd, actAddAfter, actSubtract, actSubAfter,
                                         actOr, actXor, actAnd};
  assign counting    = reqAction inside {actLess, actGreater};
  assign commit      = state == sExecute && errorQ == errNone;
  assign acknowledge = state == sExecute;
  assign error       = errorQ;
  assign dataOut     = commit ? result : heldOut;
  assign greater     = reqAction == actGreater;
  assign load        = state == sCheck && inPlace;
  assign start       = state == sCheck && counting && checkError == errNone;
  assign storeArray  = reqAction == actAlloc ? granted : reqArray;  // Clear new size

  // ------------------------------
  // Legality checks, first failure wins
  always_comb begin
    checkError = errNone;
    if (reqAction == actAlloc) begin
      if (exhausted) begin
        checkError = errOutOfMemory;
      end
    end else if ({1'b0, reqArray} >= highWater) begin
      checkError = errUnallocated;
    end else if (!isAllocated) begin
      checkError = errFreed;
    end else if ((reqAction == actRead || inPlace) && {1'b0, reqIndex} >= size) begin
      checkError = errOutOfBounds;
    end else if (reqAction == actPush && size == `HEAP_LENGTH) begin
      checkError = errFull;
    end else if (reqAction == actPop && size == '0) begin
      checkError = errEmpty;
    end
  end

  // ------------------------------
  // Datapath steering, strobes only on commit
  always_comb begin
    allocate     = 1'b0;
    releaseArray = 1'b0;
    writeEnable  = 1'b0;
    sizeWrite    = 1'b0;
    writeIndex   = reqIndex;
    writeData    = reqData;
    newSize      = size;
    result       = heldOut;
    case (reqAction)
      actAlloc: begin
        allocate  = commit;
        sizeWrite = commit;                             // Granted array starts empty
        newSize   = '0;
        result    = element_t'(granted);
      end
      actFree: releaseArray = commit;
      actWrite: begin
        writeEnable = commit;
        sizeWrite   = commit && {1'b0, reqIndex} >= size;  // Extend past the end
        newSize     = arraySize_t'(reqIndex) + 1'b1;
        result      = reqData;
      end
      actRead: result = readData;
      actSize: result = element_t'(size);
      actPush: begin
        writeIndex  = elementIndex_t'(size);            // Append at the end
        writeEnable = commit;
        sizeWrite   = commit;
        newSize     = size + 1'b1;
        result      = reqData;                          // Echo like a write
      end
      actPop: begin
        writeIndex = elementIndex_t'(size - 1'b1);      // Last element
        sizeWrite  = commit;
        newSize    = size - 1'b1;
        result     = readData;
      end
      actLess, actGreater: result = element_t'(count);
      default: begin                                    // In-place operations
        writeEnable = commit;
        writeData   = newValue;
        result      = returnValue;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= sIdle;
      errorQ  <= errNone;
      heldOut <= '0;
    end else begin
      case (state)
        sIdle: if (cycle && strobe) state <= sCheck;
        sCheck: begin
          errorQ <= checkError;
          state  <= (counting && checkError == errNone) ? sWait : sExecute;
        end
        sWait: if (done) state <= sExecute;             // Scan finished
        default: begin
          heldOut <= dataOut;                           // Hold until next acknowledge
          state   <= sIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == sIdle && cycle && strobe) begin
      reqAction <= action;
      reqArray  <= array;
      reqIndex  <= index;
      reqData   <= dataIn;
    end
  end

  // The client holds strobe until the acknowledge cycle
  assert property (@(posedge clock) disable iff (reset) acknowledge |-> strobe && cycle)
    else $error("acknowledge without strobe");

endmodule

`default_nettype wire

// File: heapPkg.sv
// Shared types of the array heap
// Action codes are 5 bits and error codes 3 bits
`default_nettype none
`include "heap_defines.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumber_t;   // Array number in the pool
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex_t;  // Position inside an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize_t;     // Element count, empty to full
  typedef logic [`HEAP_DATA_BITS-1:0]  element_t;       // One element

  typedef enum logic [4:0] {
    actAlloc    = 5'd0,                                 // Grant an array
    actFree     = 5'd1,                                 // Return an array
    actWrite    = 5'd2,
    actRead     = 5'd3,
    actSize     = 5'd4,
    actPush     = 5'd5,
    actPop      = 5'd6,
    actLess     = 5'd7,                                 // Count below dataIn
    actGreater  = 5'd8,                                 // Count above dataIn
    actAdd      = 5'd9,
    actAddAfter = 5'd10,                                // Returns old value
    actSubtract = 5'd11,
    actSubAfter = 5'd12,                                // Returns old value
    actOr       = 5'd13,
    actXor      = 5'd14,
    actAnd      = 5'd15
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone        = 3'd0,
    errUnallocated = 3'd1,                              // Never granted
    errFreed       = 3'd2,                              // Granted then freed
    errOutOfBounds = 3'd3,                              // Index at or past size
    errFull        = 3'd4,
    errEmpty       = 3'd5,
    errOutOfMemory = 3'd6                               // Pool exhausted
  } heapError_t;

endpackage

`default_nettype wire

// File: heap_defines.svh
// Width settings of the array heap
// Pool size and array length are whole powers of two of the bit counts
`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

`define HEAP_ARRAY_BITS 3                         // Bits in an array number
`define HEAP_INDEX_BITS 3                         // Bits in an element index
`define HEAP_DATA_BITS  12                        // Bits in one element

`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)       // Arrays in the pool
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)       // Elements per array

`endif

// File: rangeCounter.sv
// Counts elements strictly below or above a value, one per cycle
// done pulses size plus 1 cycles after start, count holds until next start
`timescale 1ns/1ps
`default_nettype none

module rangeCounter import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          start,                          // First scan cycle
  input  logic          greater,                        // Count above, not below
  input  arraySize_t    size,                           // Elements to visit
  input  element_t      dataIn,                         // Value compared against
  input  element_t      scanData,
  output elementIndex_t scanIndex,
  output logic          done,
  output arraySize_t    count
);

  arraySize_t step;                                     // Elements visited so far
  logic       running;
  logic       active;
  logic       hit;

  assign active    = start || running;                  // Start cycle already scans
  assign scanIndex = elementIndex_t'(step);
  assign hit       = greater ? scanData > dataIn : scanData < dataIn;

  always_ff @(posedge clock) begin
    if (reset) begin
      step    <= '0;
      running <= 1'b0;
      done    <= 1'b0;
      count   <= '0;
    end else begin
      done <= 1'b0;
      if (active) begin
        if (step < size) begin
          step    <= step + 1'b1;
          running <= 1'b1;
          count   <= (start ? '0 : count) + arraySize_t'(hit);
        end else begin
          step    <= '0;                                // Park at element 0
          running <= 1'b0;
          done    <= 1'b1;
          if (start) begin
            count <= '0;                                // Empty array
          end
        end
      end
    end
  end

  // The controller waits for done before issuing another request
  assert property (@(posedge clock) disable iff (reset) start |-> !running)
    else $error("scan started while running");

endmodule

`default_nettype wire
